//--- rtl/mem_pkg.sv
package mem_pkg;

    // ************************************************************
    // memory operations
    // ************************************************************

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,  // signed byte.
        op_lbu  = 4'd2,
        op_lh   = 4'd3,  // signed halfword.
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_t;

    // ************************************************************
    // bus encodings
    // ************************************************************

    // data_size codes.
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    localparam int BE_W = 4;  // one enable per byte lane.

    // low virtual address bits kept in the physical address.
    // the top three are cleared for the unmapped kernel segments.
    localparam int PADDR_KEEP_BITS = 29;

endpackage

//--- rtl/store_encode.sv
`timescale 1ns/1ps

module store_encode
    import mem_pkg::*;
(
    input  mem_op_t              op,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output logic                 acc_en,
    output logic                 acc_wr,
    output logic [BE_W-1:0]      acc_be,
    output logic [1:0]           acc_size,
    output logic [31:0]          acc_paddr,
    output logic [31:0]          acc_wdata,
    output logic                 addr_err
);

    logic is_byte;
    logic is_half;
    logic is_word;
    logic is_store;
    logic misaligned;

    // width of the access.
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (op)
            op_lb, op_lbu, op_sb: is_byte = 1'b1;
            op_lh, op_lhu, op_sh: is_half = 1'b1;
            op_lw, op_sw:         is_word = 1'b1;
            default:              is_byte = 1'b0;
        endcase
    end

    assign is_store = (op == op_sb) || (op == op_sh) || (op == op_sw);

    assign misaligned = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

    assign addr_err = misaligned;  // only set for a real op.
    assign acc_en   = (is_byte || is_half || is_word) && !misaligned;
    assign acc_wr   = is_store;

    // ************************************************************
    // byte enables, size and lane data
    // ************************************************************

    always_comb begin
        if (is_word) begin
            acc_be    = {BE_W{1'b1}};
            acc_size  = SIZE_WORD;
            acc_wdata = wdata;
        end else if (is_half) begin
            acc_be    = {{(BE_W-2){1'b0}}, 2'b11} << {addr[1], 1'b0};
            acc_size  = SIZE_HALF;
            acc_wdata = {2{wdata[15:0]}};  // same half in both lanes.
        end else begin
            acc_be    = {{(BE_W-1){1'b0}}, 1'b1} << addr[1:0];
            acc_size  = SIZE_BYTE;
            acc_wdata = {4{wdata[7:0]}};
        end
    end

    // fixed mapping without a tlb.
    assign acc_paddr = {{(32-PADDR_KEEP_BITS){1'b0}}, addr[PADDR_KEEP_BITS-1:0]};

endmodule

//--- rtl/data_sram_bridge.sv
`timescale 1ns/1ps

module data_sram_bridge
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // from store_encode.
    input  logic                 acc_en,
    input  logic                 acc_wr,
    input  logic [BE_W-1:0]      acc_be,
    input  logic [1:0]           acc_size,
    input  logic [31:0]          acc_paddr,
    input  logic [31:0]          acc_wdata,
    input  mem_op_t              op,

    // data bus.
    output logic                 data_req,
    output logic                 data_wr,
    output logic [1:0]           data_size,
    output logic [31:0]          data_addr,
    output logic [31:0]          data_wdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,

    // pipeline control.
    output logic                 stall,
    output logic                 flush,

    // completion towards load_extend.
    output logic                 done,
    output mem_op_t              done_op,
    output logic [1:0]           done_lane
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_hdsk = 2'd1,
        st_wait = 2'd2
    } state_t;

    state_t state;
    state_t next_state;

    // held request.
    logic               reg_wr;
    logic [BE_W-1:0]    reg_be;
    logic [1:0]         reg_size;
    logic [31:0]        reg_paddr;
    logic [31:0]        reg_wdata;
    mem_op_t            reg_op;

    // byte lane of the access from its enables and size.
    function automatic logic [1:0] lane_of(input logic [BE_W-1:0] be,
                                           input logic [1:0] size);
        logic [1:0] lane;
        lane = 2'b00;
        case (size)
            SIZE_BYTE: begin
                case (be)
                    4'b0010: lane = 2'b01;
                    4'b0100: lane = 2'b10;
                    4'b1000: lane = 2'b11;
                    default: lane = 2'b00;
                endcase
            end
            SIZE_HALF: lane = be[2] ? 2'b10 : 2'b00;
            SIZE_WORD: lane = 2'b00;
            default:   lane = 2'b00;
        endcase
        return lane;
    endfunction

    // ************************************************************
    // state machine
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (acc_en) begin
                    next_state = data_addr_ok ? st_wait : st_hdsk;
                end
            end
            st_hdsk: begin
                if (data_addr_ok) begin
                    next_state = st_wait;
                end
            end
            st_wait: begin
                if (data_data_ok) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // capture on the first request cycle.
    always_ff @(posedge clk) begin
        if (state == st_idle && acc_en) begin
            reg_wr    <= acc_wr;
            reg_be    <= acc_be;
            reg_size  <= acc_size;
            reg_paddr <= acc_paddr;
            reg_wdata <= acc_wdata;
            reg_op    <= op;
        end
    end

    // ************************************************************
    // bus and pipeline outputs
    // ************************************************************

    always_comb begin
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = SIZE_BYTE;
        data_addr  = 32'd0;
        data_wdata = 32'd0;
        stall      = 1'b0;
        flush      = 1'b0;
        case (state)
            st_idle: begin
                if (acc_en) begin  // live fields.
                    data_req   = 1'b1;
                    data_wr    = acc_wr;
                    data_size  = acc_size;
                    data_addr  = {acc_paddr[31:2], lane_of(acc_be, acc_size)};
                    data_wdata = acc_wr ? acc_wdata : 32'd0;
                    stall      = 1'b1;
                    flush      = 1'b1;
                end
            end
            st_hdsk: begin  // held fields including the write flag.
                data_req   = 1'b1;
                data_wr    = reg_wr;
                data_size  = reg_size;
                data_addr  = {reg_paddr[31:2], lane_of(reg_be, reg_size)};
                data_wdata = reg_wr ? reg_wdata : 32'd0;
                stall      = 1'b1;
                flush      = 1'b1;
            end
            st_wait: begin
                if (!data_data_ok) begin
                    stall = 1'b1;
                    flush = 1'b1;
                end
            end
            default: begin
                stall = 1'b0;
            end
        endcase
    end

    assign done      = (state == st_wait) && data_data_ok;
    assign done_op   = reg_op;
    assign done_lane = lane_of(reg_be, reg_size);

endmodule

//--- rtl/load_extend.sv
`timescale 1ns/1ps

module load_extend
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         done,
    input  mem_op_t      done_op,
    input  logic [1:0]   done_lane,
    input  logic [31:0]  data_rdata,
    output logic         load_valid,
    output logic [31:0]  load_data
);

    logic        is_load;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] ext_data;

    // lane select.
    assign sel_byte = data_rdata[{done_lane, 3'b000} +: 8];
    assign sel_half = data_rdata[{done_lane[1], 4'b0000} +: 16];

    // ************************************************************
    // sign and zero extension
    // ************************************************************

    always_comb begin
        is_load  = 1'b1;
        ext_data = data_rdata;
        case (done_op)
            op_lb:   ext_data = {{24{sel_byte[7]}}, sel_byte};
            op_lbu:  ext_data = {24'd0, sel_byte};
            op_lh:   ext_data = {{16{sel_half[15]}}, sel_half};
            op_lhu:  ext_data = {16'd0, sel_half};
            op_lw:   ext_data = data_rdata;
            default: is_load  = 1'b0;  // stores end here.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= done && is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (done && is_load) begin
            load_data <= ext_data;
        end
    end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // pipeline side.
    input  mem_op_t      op,
    input  logic [31:0]  addr,
    input  logic [31:0]  wdata,
    output logic         stall,
    output logic         flush,
    output logic         addr_err,
    output logic         load_valid,
    output logic [31:0]  load_data,

    // data bus.
    output logic         data_req,
    output logic         data_wr,
    output logic [1:0]   data_size,
    output logic [31:0]  data_addr,
    output logic [31:0]  data_wdata,
    input  logic [31:0]  data_rdata,
    input  logic         data_addr_ok,
    input  logic         data_data_ok
);

    logic               acc_en;
    logic               acc_wr;
    logic [BE_W-1:0]    acc_be;
    logic [1:0]         acc_size;
    logic [31:0]        acc_paddr;
    logic [31:0]        acc_wdata;
    logic               done;
    mem_op_t            done_op;
    logic [1:0]         done_lane;

    // ************************************************************
    // encode, bus handshake, load extend
    // ************************************************************

    store_encode u_store_encode (
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .acc_en    (acc_en),
        .acc_wr    (acc_wr),
        .acc_be    (acc_be),
        .acc_size  (acc_size),
        .acc_paddr (acc_paddr),
        .acc_wdata (acc_wdata),
        .addr_err  (addr_err)
    );

    data_sram_bridge u_bridge (
        .clk          (clk),
        .rst          (rst),
        .acc_en       (acc_en),
        .acc_wr       (acc_wr),
        .acc_be       (acc_be),
        .acc_size     (acc_size),
        .acc_paddr    (acc_paddr),
        .acc_wdata    (acc_wdata),
        .op           (op),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .stall        (stall),
        .flush        (flush),
        .done         (done),
        .done_op      (done_op),
        .done_lane    (done_lane)
    );

    load_extend u_load_extend (
        .clk        (clk),
        .rst        (rst),
        .done       (done),
        .done_op    (done_op),
        .done_lane  (done_lane),
        .data_rdata (data_rdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

//--- test/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions
    import mem_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         stall,
    input logic         flush,
    input logic         addr_err,
    input logic         load_valid,
    input logic         data_req,
    input logic         data_wr,
    input logic [1:0]   data_size,
    input logic [31:0]  data_addr,
    input logic [31:0]  data_wdata,
    input logic         data_addr_ok,
    input logic         data_data_ok,
    input logic         done,
    input mem_op_t      done_op
);

    logic pending;  // address accepted, data phase open.
    logic done_load;

    assign done_load = done && (done_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw});

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (data_data_ok) begin
            pending <= 1'b0;
        end else if (data_req && data_addr_ok) begin
            pending <= 1'b1;
        end
    end

    // ************************************************************
    // bus handshake
    // ************************************************************

    assert property (@(posedge clk) disable iff (rst)
        data_req && !data_addr_ok |=> data_req && $stable(data_wr) && $stable(data_size)
            && $stable(data_addr) && $stable(data_wdata))
        else $error("request fields changed before data_addr_ok");

    assert property (@(posedge clk) disable iff (rst) data_data_ok |-> !stall)
        else $error("stall high in the data_data_ok cycle");

    assert property (@(posedge clk) disable iff (rst)
        (data_req || pending) && !data_data_ok |-> stall)
        else $error("stall dropped before the data phase ended");

    assert property (@(posedge clk) disable iff (rst) flush == stall)
        else $error("flush does not follow stall");

    assert property (@(posedge clk) disable iff (rst) addr_err |-> !data_req && !stall)
        else $error("misaligned access reached the bus");

    assert property (@(posedge clk) disable iff (rst) data_req |-> data_addr[31:29] == 3'b000)
        else $error("unmapped address bits on data_addr");

    // ************************************************************
    // load completion and reset
    // ************************************************************

    assert property (@(posedge clk) disable iff (rst) done_load |=> load_valid)
        else $error("load_valid missing after a load completion");

    assert property (@(posedge clk) disable iff (rst) load_valid |-> $past(done_load))
        else $error("load_valid without a load completion one cycle before");

    assert property (@(posedge clk)
        rst |=> !data_req && !stall && !flush && !load_valid && !addr_err)
        else $error("outputs active during or right after reset");

endmodule

bind mem_stage mem_stage_assertions u_assertions (.*);

//--- test/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage
    import mem_pkg::*;
;

    localparam int N_OPS      = 84;
    localparam int OP_CYCLES  = 10;  // one above the worst case of both slave waits at 3.
    localparam int RST_CYCLES = 10;
    localparam int MAX_CYCLES = N_OPS * OP_CYCLES + RST_CYCLES;

    logic clk = 1'b0;
    logic rst;
    mem_op_t op;
    logic [31:0] addr, wdata, load_data, data_addr, data_wdata;
    logic stall, flush, addr_err, load_valid, data_req, data_wr;
    logic [1:0] data_size;
    logic [31:0] data_rdata = 32'd0;
    logic data_addr_ok = 1'b0;
    logic data_data_ok = 1'b0;

    logic [31:0] mem [256];
    logic [31:0] shadow [256];
    logic [31:0] stim_rng = 32'd41166;
    logic [31:0] slave_rng = 32'd41166 ^ 32'h5555_aaaa;
    logic [31:0] r, base, a;
    logic [1:0] slave_wait;
    logic [7:0] acc_idx;
    logic in_data;
    int errors = 0;
    int checks = 0;
    int err_mark = 0;
    int cycles = 0;

    mem_stage uut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, 8'hc3 - i};
    endfunction

    // bytes of a bus write picked by size and address low bits.
    function automatic logic [31:0] bus_write(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [1:0] size, input logic [1:0] lane);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (size == SIZE_WORD || (size == SIZE_HALF && b[1] == lane[1])
                    || (size == SIZE_BYTE && b[1:0] == lane)) begin
                res[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] load_expect(input mem_op_t o, input logic [31:0] w,
                                                input logic [1:0] lane);
        logic [7:0] b;
        logic [15:0] h;
        case (lane)
            2'd0:    b = w[7:0];
            2'd1:    b = w[15:8];
            2'd2:    b = w[23:16];
            default: b = w[31:24];
        endcase
        h = lane[1] ? w[31:16] : w[15:0];
        case (o)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'd0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'd0, h};
            default: return w;
        endcase
    endfunction

    // ************************************************************
    // bus slave with random waits
    // ************************************************************

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) mem[i] = fill_word(8'(i));
            in_data = 1'b0;
            slave_wait = 2'd0;
            data_addr_ok <= #1 1'b0;
            data_data_ok <= #1 1'b0;
        end else if (data_data_ok) begin
            data_data_ok <= #1 1'b0;
            in_data = 1'b0;
            slave_rng = xorshift(slave_rng);
            slave_wait = slave_rng[1:0];
            data_addr_ok <= #1 (slave_wait == 2'd0);  // zero wait answers at once.
        end else if (in_data) begin
            if (slave_wait <= 2'd1) begin
                data_data_ok <= #1 1'b1;
                data_rdata <= #1 mem[acc_idx];
            end else begin
                slave_wait = slave_wait - 2'd1;
            end
        end else if (data_req && data_addr_ok) begin
            acc_idx = data_addr[9:2];
            if (data_wr) mem[acc_idx] = bus_write(mem[acc_idx], data_wdata, data_size,
                                                   data_addr[1:0]);
            in_data = 1'b1;
            data_addr_ok <= #1 1'b0;
            slave_rng = xorshift(slave_rng);
            slave_wait = slave_rng[1:0];
            if (slave_wait == 2'd0) begin
                data_data_ok <= #1 1'b1;
                data_rdata <= #1 mem[acc_idx];
            end
        end else if (data_req) begin
            if (slave_wait <= 2'd1) data_addr_ok <= #1 1'b1;
            else slave_wait = slave_wait - 2'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ************************************************************
    // stimulus and checks
    // ************************************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_rand();
        stim_rng = xorshift(stim_rng);
        r = stim_rng;
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // starts and ends a small delay after a rising edge.
    task automatic run_op(input mem_op_t o, input logic [31:0] ad, input logic [31:0] wd);
        logic [7:0] idx;
        logic misal;
        idx = ad[9:2];
        op = o;
        addr = ad;
        wdata = wd;
        misal = ((o == op_lh || o == op_lhu || o == op_sh) && ad[0])
             || ((o == op_lw || o == op_sw) && ad[1:0] != 2'b00);
        #4;
        if (misal) begin
            check_value("addr_err", 32'(addr_err), 32'd1);
            check_value("stall", 32'(stall), 32'd0);
            check_value("data_req", 32'(data_req), 32'd0);
        end else begin
            while (stall) begin
                @(posedge clk);
                #5;
            end
            case (o)
                op_sb:   shadow[idx][{ad[1:0], 3'b000} +: 8] = wd[7:0];
                op_sh:   shadow[idx][{ad[1], 4'b0000} +: 16] = wd[15:0];
                op_sw:   shadow[idx] = wd;
                default: ;
            endcase
        end
        @(posedge clk);
        #1;
        op = op_none;
        #4;
        if (!misal && o inside {op_lb, op_lbu, op_lh, op_lhu, op_lw}) begin
            check_value("load_valid", 32'(load_valid), 32'd1);
            check_value("load_data", load_data, load_expect(o, shadow[idx], ad[1:0]));
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        for (int i = 0; i < 256; i++) shadow[i] = fill_word(8'(i));
        rst = 1'b1;
        op = op_none;
        addr = 32'd0;
        wdata = 32'd0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        for (int k = 0; k < 4; k++) begin
            next_rand();
            base = {22'd0, r[7:0], 2'b00};
            next_rand();
            run_op(op_sw, base, r);
            run_op(op_lw, base, 32'd0);
        end
        end_test("word store and load");

        base = 32'h0000_0120;
        for (int l = 0; l < 4; l++) begin
            next_rand();
            run_op(op_sb, base + 32'(l), r);
            run_op(op_lw, base, 32'd0);
        end
        for (int h = 0; h < 2; h++) begin
            next_rand();
            run_op(op_sh, base + 32'(2 * h), r);
            run_op(op_lw, base, 32'd0);
        end
        end_test("byte and halfword stores");

        next_rand();
        for (int k = 0; k < 2; k++) begin
            base = 32'h0000_0200 + 32'(4 * k);
            run_op(op_sw, base, (k == 0) ? r : 32'h8ffe_80ff);  // sign bits in every lane.
            for (int l = 0; l < 4; l++) begin
                run_op(op_lb, base + 32'(l), 32'd0);
                run_op(op_lbu, base + 32'(l), 32'd0);
            end
            for (int h = 0; h < 2; h++) begin
                run_op(op_lh, base + 32'(2 * h), 32'd0);
                run_op(op_lhu, base + 32'(2 * h), 32'd0);
            end
        end
        end_test("load extension");

        base = 32'h0000_0300;
        run_op(op_lh, base + 32'd1, 32'd0);
        run_op(op_sw, base + 32'd2, 32'hdead_beef);
        run_op(op_sh, base + 32'd3, 32'hbeef_dead);
        run_op(op_lw, base, 32'd0);  // word still holds its fill.
        end_test("misaligned access");

        for (int k = 0; k < 30; k++) begin
            next_rand();
            op = mem_op_t'({1'b0, r[2:0]} + 4'd1);
            a = {22'd0, r[15:8], r[17:16]};
            if (op inside {op_lh, op_lhu, op_sh}) a[0] = 1'b0;
            if (op inside {op_lw, op_sw}) a[1:0] = 2'b00;
            run_op(op, a, xorshift(r));
        end
        end_test("random traffic");

        for (int k = 0; k < 2; k++) begin
            next_rand();
            base = {22'd0, r[7:0], 2'b00};
            run_op(op_sw, base | (k == 0 ? 32'ha000_0000 : 32'he000_0000), xorshift(r));
            run_op(op_lw, base, 32'd0);
        end
        end_test("address mapping");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- mem_access.f
rtl/mem_pkg.sv
rtl/store_encode.sv
rtl/data_sram_bridge.sv
rtl/load_extend.sv
rtl/mem_stage.sv
test/mem_stage_assertions.sv
test/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -f mem_access.f --top-module tb_mem_stage -o sim_mem_stage &&
./obj_dir/sim_mem_stage | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }
